// File: digital_cam.f
src/vga_pkg.sv
src/ir_cmd_pkg.sv
src/vga_timing.sv
src/ir_command_decoder.sv
src/display_gate.sv
src/pixel_pipeline.sv
src/digital_cam_top.sv
test/tb_digital_cam.sv

// File: Bender.yml
package:
  name: digital_cam

sources:
  - src/vga_pkg.sv
  - src/ir_cmd_pkg.sv
  - src/vga_timing.sv
  - src/ir_command_decoder.sv
  - src/display_gate.sv
  - src/pixel_pipeline.sv
  - src/digital_cam_top.sv
  - target: test
    files:
      - test/tb_digital_cam.sv

// File: test/tb_digital_cam.sv
module tb_digital_cam;
    timeunit 1ns;
    timeprecision 1ps;

    import vga_pkg::*;
    import ir_cmd_pkg::*;

    localparam int     clk_period   = 8;
    localparam int     frame_cycles = h_total * v_total;
    localparam int     buf_words    = buf_width * (v_active / 2);
    localparam int     end_frame    = 3;
    localparam int     end_line     = 20;     // a few lines of the reopened frame
    localparam longint run_cycles   = end_frame * frame_cycles + end_line * h_total;
    localparam longint watchdog_ns  = (run_cycles + 50_000) * clk_period;

    // expected pixel with the request's active flag and mode
    typedef struct packed {
        logic       act;
        disp_mode_t mode;
        rgb888_t    pix;
    } exp_pix_t;

    logic      clk_25_vga;
    logic      rst_n;
    logic      ir_valid;
    ir_code_t  ir_code;
    logic      frame_done;
    logic      resend;
    buf_addr_t rd_addr;
    rgb565_t   rd_data;
    logic      vga_hsync;
    logic      vga_vsync;
    logic      vga_blank_n;
    rgb888_t   vga_rgb;

    rgb565_t     fb_mem [buf_words];
    buf_addr_t   addr_hist [2];         // [0] one cycle back, [1] two cycles back
    exp_pix_t    exp_q [$];
    logic [31:0] rng;

    digital_cam_top u_dut (
        .clk_25_vga  (clk_25_vga),
        .rst_n       (rst_n),
        .ir_valid    (ir_valid),
        .ir_code     (ir_code),
        .frame_done  (frame_done),
        .resend      (resend),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_blank_n (vga_blank_n),
        .vga_rgb     (vga_rgb)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RGB565 to RGB888 with ones in the low bits, optional luma
    function automatic rgb888_t expand_pixel(input rgb565_t w, input disp_mode_t mode);
        int      r;
        int      g;
        int      b;
        int      y;
        rgb888_t p;
        r = int'(w[15:11]) * 8 + 7;
        g = int'(w[10:5]) * 4 + 3;
        b = int'(w[4:0]) * 8 + 7;
        y = (gray_w_r * r + gray_w_g * g + gray_w_b * b) / 256;
        if (mode == mode_gray) begin
            p = '{r: chan_t'(y), g: chan_t'(y), b: chan_t'(y)};
        end else begin
            p = '{r: chan_t'(r), g: chan_t'(g), b: chan_t'(b)};
        end
        return p;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        clk_25_vga = 1'b0;
        forever #(clk_period / 2) clk_25_vga = ~clk_25_vga;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run never reached its end", watchdog_ns);
        $display("TESTS FAILED");
        $fatal(1);
    end

    // ====================================================================
    // stimulus, reference model and checks, all on the falling edge
    // ====================================================================
    initial begin
        int         mx;
        int         my;
        int         mframe;
        bit         started;
        int         hs_low;
        int         vs_low;
        int         act_cnt;
        int         n_orig;
        int         n_gray;
        int         n_reopen;
        int         gray_x;
        int         orig_x;
        logic       exp_hs;
        logic       exp_vs;
        logic       exp_act;
        buf_addr_t  exp_addr;
        exp_pix_t   e;
        exp_pix_t   e_new;
        rgb888_t    want;
        disp_mode_t m_mode;
        logic       m_frame_seen;
        logic       m_disp_en;
        logic       vs_d1;
        logic       vs_d2;
        logic       prev_valid;
        logic       prev_done;
        logic       prev_resend;
        ir_code_t   prev_code;

        rst_n      = 1'b0;
        ir_valid   = 1'b0;
        ir_code    = '0;
        frame_done = 1'b0;
        resend     = 1'b0;
        rd_data    = '0;
        rng        = 32'h867;
        for (int i = 0; i < buf_words; i++) begin
            rng       = lcg_next(rng);
            fb_mem[i] = rgb565_t'(rng >> 16);
        end
        rng    = lcg_next(rng);
        gray_x = int'(rng[31:16] % h_total);
        rng    = lcg_next(rng);
        orig_x = int'(rng[31:16] % h_total);

        addr_hist    = '{default: '0};
        m_mode       = mode_orig;
        m_frame_seen = 1'b0;
        m_disp_en    = 1'b0;
        vs_d1        = 1'b1;          // sync idles high after reset
        vs_d2        = 1'b1;
        {prev_valid, prev_done, prev_resend, prev_code} = '0;
        {mx, my, mframe, hs_low, vs_low, act_cnt} = '0;
        {n_orig, n_gray, n_reopen} = '0;
        started = 1'b0;

        repeat (3) @(posedge clk_25_vga);
        @(negedge clk_25_vga);
        rst_n = 1'b1;

        while (!(mframe == end_frame && my == end_line)) begin
            // raster the DUT should show in this cycle
            if (!started) begin
                {exp_hs, exp_vs, exp_act} = 3'b110;
            end else begin
                exp_act = (mx < h_active) && (my < v_active);
                exp_hs  = !(mx >= h_active + h_front && mx < h_active + h_front + h_sync);
                exp_vs  = !(my >= v_active + v_front && my < v_active + v_front + v_sync);
            end
            exp_addr = exp_act ? buf_addr_t'((my / 2) * buf_width + mx / 2) : '0;
            compare_value("vga_hsync", vga_hsync, exp_hs);
            compare_value("vga_vsync", vga_vsync, exp_vs);
            compare_value("vga_blank_n", vga_blank_n, exp_act);
            compare_value("rd_addr", rd_addr, exp_addr);

            // registers as they stand after the last rising edge
            if (!m_frame_seen) begin
                m_disp_en = 1'b0;
            end else if (!vs_d2 && vs_d1) begin
                m_disp_en = 1'b1;
            end
            if (prev_resend) begin
                m_frame_seen = 1'b0;       // resend beats frame_done
            end else if (prev_done) begin
                m_frame_seen = 1'b1;
            end
            if (prev_valid && prev_code == key_orig) begin
                m_mode = mode_orig;
            end else if (prev_valid && prev_code == key_gray) begin
                m_mode = mode_gray;
            end
            vs_d2 = vs_d1;
            vs_d1 = exp_vs;

            e_new = '{act: exp_act, mode: m_mode, pix: expand_pixel(fb_mem[exp_addr], m_mode)};
            exp_q.push_back(e_new);
            if (exp_q.size() > pix_lat) begin
                e    = exp_q.pop_front();
                want = (e.act && m_disp_en) ? e.pix : '0;
                compare_value("vga_rgb", vga_rgb, want);
                if (e.act && m_disp_en) begin
                    if (mframe == end_frame) begin
                        n_reopen++;
                    end else if (e.mode == mode_gray) begin
                        n_gray++;
                    end else begin
                        n_orig++;
                    end
                end
            end

            if (!started) begin
                started = 1'b1;
            end else begin
                if (mframe == 0) begin
                    hs_low  += !vga_hsync;
                    vs_low  += !vga_vsync;
                    act_cnt += vga_blank_n;
                end
                mx++;
                if (mx == h_total) begin
                    mx = 0;
                    my++;
                    if (my == v_total) begin
                        my = 0;
                        mframe++;
                        if (mframe == 1) begin
                            compare_value("hsync low cycles", hs_low, h_sync * v_total);
                            compare_value("vsync low cycles", vs_low, v_sync * h_total);
                            compare_value("blank_n high cycles", act_cnt, h_active * v_active);
                        end
                    end
                end
            end

            // inputs for the next rising edge
            frame_done = (mframe == 0 && my == 485 && mx == 0) ||
                         (mframe == 2 && my == 240 && mx == 0);
            resend     = (mframe == 1 && my == 485 && mx == 100);
            rng        = lcg_next(rng);
            if (mframe == 1 && my == 120 && mx == gray_x) begin
                ir_valid = 1'b1;
                ir_code  = key_gray;
            end else if (mframe == 1 && my == 360 && mx == orig_x) begin
                ir_valid = 1'b1;
                ir_code  = key_orig;
            end else if (rng[31:21] == '0) begin
                ir_valid = 1'b1;                  // stray key, no mode behind it
                ir_code  = rng[15:8];
                if (ir_code == key_orig || ir_code == key_gray) begin
                    ir_code = ir_code ^ 8'h80;
                end
            end else begin
                ir_valid = 1'b0;
                ir_code  = rng[15:8];
            end

            // frame buffer answers two cycles after the address
            rd_data      = (addr_hist[1] < buf_words) ? fb_mem[addr_hist[1]] : '0;
            addr_hist[1] = addr_hist[0];
            addr_hist[0] = rd_addr;

            prev_valid  = ir_valid;
            prev_code   = ir_code;
            prev_done   = frame_done;
            prev_resend = resend;
            @(negedge clk_25_vga);
        end

        compare_value("original pixels shown", n_orig != 0, 1'b1);
        compare_value("gray pixels shown", n_gray != 0, 1'b1);
        compare_value("pixels after reopen", n_reopen != 0, 1'b1);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: src/digital_cam_top.sv
module digital_cam_top (
    input  logic                 clk_25_vga,
    input  logic                 rst_n,
    input  logic                 ir_valid,
    input  ir_cmd_pkg::ir_code_t ir_code,
    input  logic                 frame_done,
    input  logic                 resend,
    output vga_pkg::buf_addr_t   rd_addr,
    input  vga_pkg::rgb565_t     rd_data,
    output logic                 vga_hsync,
    output logic                 vga_vsync,
    output logic                 vga_blank_n,
    output vga_pkg::rgb888_t     vga_rgb
);
    import vga_pkg::*;
    import ir_cmd_pkg::*;

    vid_ctrl_t  vid;
    disp_mode_t mode_sel;
    logic       disp_en;

    vga_timing u_timing (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .vid        (vid)
    );

    ir_command_decoder u_ir_dec (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .ir_valid   (ir_valid),
        .ir_code    (ir_code),
        .mode_sel   (mode_sel)
    );

    display_gate u_gate (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .frame_done (frame_done),
        .resend     (resend),
        .vsync      (vid.vsync),
        .disp_en    (disp_en)
    );

    pixel_pipeline u_pix (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .vid        (vid),
        .rd_data    (rd_data),
        .mode_sel   (mode_sel),
        .disp_en    (disp_en),
        .vga_rgb    (vga_rgb)
    );

    assign rd_addr     = vid.addr;
    assign vga_hsync   = vid.hsync;     // syncs leave undelayed
    assign vga_vsync   = vid.vsync;
    assign vga_blank_n = vid.active;

endmodule

// File: src/pixel_pipeline.sv
module pixel_pipeline (
    input  logic                   clk_25_vga,
    input  logic                   rst_n,
    input  vga_pkg::vid_ctrl_t     vid,
    input  vga_pkg::rgb565_t       rd_data,
    input  ir_cmd_pkg::disp_mode_t mode_sel,
    input  logic                   disp_en,
    output vga_pkg::rgb888_t       vga_rgb
);
    import vga_pkg::*;
    import ir_cmd_pkg::*;

    // per-pixel control that travels beside the read request
    typedef struct packed {
        logic       active;
        disp_mode_t mode;
    } pix_ctrl_t;

    pix_ctrl_t [mem_rd_lat-1:0] req_q;      // waits out the RAM latency
    pix_ctrl_t                  in_ctrl;
    rgb565_t                    in_pix;

    rgb888_t     exp_rgb;
    logic [15:0] gray_sum;
    chan_t       gray;
    rgb888_t     sel_rgb;

    logic    [align_lat-1:0] act_pipe;
    rgb888_t [align_lat-1:0] rgb_pipe;

    // ====================================================================
    // match control to the returning read data
    // ====================================================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            req_q   <= '0;
            in_ctrl <= '0;
        end else begin
            req_q   <= {req_q[mem_rd_lat-2:0], pix_ctrl_t'{vid.active, mode_sel}};
            in_ctrl <= req_q[mem_rd_lat-1];
        end
    end

    always_ff @(posedge clk_25_vga) begin
        in_pix <= rd_data;      // input register, lines up with in_ctrl
    end

    // ====================================================================
    // colour conversion
    // ====================================================================
    // pad low bits with ones so full scale stays near 255
    always_comb begin
        exp_rgb.r = {in_pix[15:11], 3'b111};
        exp_rgb.g = {in_pix[10:5], 2'b11};
        exp_rgb.b = {in_pix[4:0], 3'b111};
    end

    assign gray_sum = 16'(gray_w_r * exp_rgb.r +
                          gray_w_g * exp_rgb.g +
                          gray_w_b * exp_rgb.b);
    assign gray     = gray_sum[15:8];

    assign sel_rgb = (in_ctrl.mode == mode_gray) ? {gray, gray, gray} : exp_rgb;

    // ====================================================================
    // alignment delay, cleared each vertical sync
    // ====================================================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            act_pipe <= '0;
        end else if (!vid.vsync) begin
            act_pipe <= '0;
        end else begin
            act_pipe <= {act_pipe[align_lat-2:0], in_ctrl.active};
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (!vid.vsync) begin
            rgb_pipe <= '0;
        end else begin
            rgb_pipe <= {rgb_pipe[align_lat-2:0], sel_rgb};
        end
    end

    // blank outside the picture and until the gate opens
    assign vga_rgb = (act_pipe[align_lat-1] && disp_en) ? rgb_pipe[align_lat-1] : '0;

    // a request outside the active area must come out black
    a_blank_out: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        !$past(vid.active, pix_lat) |-> vga_rgb == '0);

endmodule

// File: src/display_gate.sv
module display_gate (
    input  logic clk_25_vga,
    input  logic rst_n,
    input  logic frame_done,
    input  logic resend,
    input  logic vsync,
    output logic disp_en
);

    logic frame_seen;   // at least one frame in the buffer
    logic vsync_q;

    // ====================================================================
    // first-frame flag
    // ====================================================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            frame_seen <= 1'b0;
        end else if (resend) begin      // resend wins over frame_done
            frame_seen <= 1'b0;
        end else if (frame_done) begin
            frame_seen <= 1'b1;
        end
    end

    // ====================================================================
    // enable opens on the next frame boundary
    // ====================================================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            vsync_q <= 1'b1;            // idle level, no false edge
            disp_en <= 1'b0;
        end else begin
            vsync_q <= vsync;
            if (!frame_seen) begin
                disp_en <= 1'b0;
            end else if (!vsync_q && vsync) begin
                disp_en <= 1'b1;
            end
        end
    end

    a_no_early_enable: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        $rose(disp_en) |-> $past(frame_seen));

endmodule

// File: src/ir_command_decoder.sv
module ir_command_decoder (
    input  logic                   clk_25_vga,
    input  logic                   rst_n,
    input  logic                   ir_valid,
    input  ir_cmd_pkg::ir_code_t   ir_code,
    output ir_cmd_pkg::disp_mode_t mode_sel
);
    import ir_cmd_pkg::*;

    // ====================================================================
    // mode register
    // ====================================================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            mode_sel <= mode_orig;
        end else if (ir_valid) begin
            case (ir_code)
                key_orig: mode_sel <= mode_orig;
                key_gray: mode_sel <= mode_gray;
                default: begin
                    // filter, tracking and threshold keys have no mode here
                    mode_sel <= mode_sel;
                end
            endcase
        end
    end

endmodule

// File: src/vga_timing.sv
module vga_timing (
    input  logic               clk_25_vga,
    input  logic               rst_n,
    output vga_pkg::vid_ctrl_t vid
);
    import vga_pkg::*;

    logic [$clog2(h_total)-1:0] h_cnt;
    logic [$clog2(v_total)-1:0] v_cnt;

    logic      active_c;
    logic      hsync_c;
    logic      vsync_c;
    buf_addr_t addr_c;

    // ====================================================================
    // raster counters
    // ====================================================================
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_total - 1) begin
            h_cnt <= '0;
            if (v_cnt == v_total - 1) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ====================================================================
    // decode, then register
    // ====================================================================
    assign active_c = (h_cnt < h_active) && (v_cnt < v_active);
    assign hsync_c  = !((h_cnt >= h_active + h_front) &&
                        (h_cnt <  h_active + h_front + h_sync));   // active low
    assign vsync_c  = !((v_cnt >= v_active + v_front) &&
                        (v_cnt <  v_active + v_front + v_sync));

    // each buffer pixel covers a 2x2 block of the screen
    assign addr_c = active_c ?
        buf_addr_t'(v_cnt >> 1) * buf_addr_t'(buf_width) + buf_addr_t'(h_cnt >> 1) : '0;

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            vid <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0, addr: '0};
        end else begin
            vid <= '{hsync: hsync_c, vsync: vsync_c, active: active_c, addr: addr_c};
        end
    end

    a_h_range: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        h_cnt < h_total);
    a_v_range: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        v_cnt < v_total);
    // address must stay inside the 320x240 buffer
    a_addr_range: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        vid.active |-> vid.addr < buf_width * (v_active / 2));

endmodule

// File: src/ir_cmd_pkg.sv
package ir_cmd_pkg;

    // ====================================================================
    // remote key codes
    // ====================================================================
    typedef logic [7:0] ir_code_t;

    // only the keys whose modes exist in this design
    localparam ir_code_t key_orig = 8'h12;  // OK key
    localparam ir_code_t key_gray = 8'h0F;  // key A

    // ====================================================================
    // display modes
    // ====================================================================
    // single bit is enough while only two modes remain
    typedef enum logic [0:0] {
        mode_orig = 1'b0,
        mode_gray = 1'b1
    } disp_mode_t;

endpackage

// File: src/vga_pkg.sv
package vga_pkg;

    // ====================================================================
    // 640x480 raster at 25 MHz
    // ====================================================================
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_total  = 800;

    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_total  = 525;

    localparam int buf_width = 320;     // half-resolution row length

    // ====================================================================
    // pixel path latencies
    // ====================================================================
    localparam int mem_rd_lat = 2;      // external frame buffer
    localparam int align_lat  = 7;      // kept at the filter-path depth
    localparam int pix_lat    = mem_rd_lat + align_lat + 1;  // +1 input register

    // luma weights, sum is 252 so the >>8 never overflows a channel
    localparam int gray_w_r = 76;
    localparam int gray_w_g = 150;
    localparam int gray_w_b = 26;

    typedef logic [16:0] buf_addr_t;
    typedef logic [15:0] rgb565_t;
    typedef logic [7:0]  chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb888_t;

    // raster outputs of the timing generator
    typedef struct packed {
        logic      hsync;
        logic      vsync;
        logic      active;
        buf_addr_t addr;
    } vid_ctrl_t;

endpackage
